// File: Makefile
# Verilator build and run of the FIR filter testbench.
# Any variable can be overridden on the command line.

VERILATOR       ?= verilator
TOP             ?= firFilterBench
FILE_LIST       ?= compile.f
OBJ_DIR         ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MESSAGE    ?= ALL CHECKS PASSED

.PHONY: simulate clean

# Build, run, and fail unless the pass message appears in the output.
simulate:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MESSAGE)"

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
source/firPackage.sv
source/firCoeffLoader.sv
source/firSampleLine.sv
source/firProductSum.sv
source/firFilterTop.sv
test/firFilterBench.sv

// File: source/firCoeffLoader.sv
//////////////////////////////////////////////////
// Coefficient loader for the FIR filter.
// While loadEnable is held high it streams the fixed
// table, one entry per clock, then raises coeffReady.
//////////////////////////////////////////////////

module firCoeffLoader (
	input  logic                                      clock,
	input  logic                                      rst,
	input  logic                                      loadEnable,
	output logic                                      coeffValid,
	output logic signed [firPackage::coeffWidth-1:0]  coeffOut,
	output logic                                      coeffReady
);

	import firPackage::*;

	// Index of the next table entry to send.
	// It stops on the last entry once the table has gone out.
	logic [coeffIndexWidth-1:0] coeffIndex;

	// Index of the final table entry, sized to match the counter.
	localparam logic [coeffIndexWidth-1:0] lastIndex = coeffIndexWidth'(tapCount - 1);

	// Control state of the loader.
	// A low enable restarts the whole sequence from entry 0.
	always_ff @(posedge clock) begin
		if (rst) begin
			coeffIndex <= '0;
			coeffValid <= 1'b0;
			coeffReady <= 1'b0;
		end else if (!loadEnable) begin
			coeffIndex <= '0;
			coeffValid <= 1'b0;
			coeffReady <= 1'b0;
		end else if (!coeffReady) begin
			// Still streaming, so every edge sends one entry.
			coeffValid <= 1'b1;
			if (coeffIndex == lastIndex) begin
				// The last entry goes out on this edge.
				// Ready rises together with it.
				coeffReady <= 1'b1;
			end else begin
				coeffIndex <= coeffIndex + 1'b1;
			end
		end else begin
			// The table is complete.
			// Ready holds while the enable stays high.
			coeffValid <= 1'b0;
		end
	end

	// The coefficient word itself.
	// It is only read by the bank while coeffValid is high.
	always_ff @(posedge clock) begin
		if (loadEnable && !coeffReady) begin
			coeffOut <= coeffTable[coeffIndex];
		end
	end

	// Once ready has been up for a full cycle, no further words may be pushed.
	// An extra push would shift the bank and misalign every tap.
	assert property (@(posedge clock) disable iff (rst)
		($past(coeffReady) && coeffReady) |-> !coeffValid)
		else $error("coefficient pushed after the table was complete");

endmodule

// File: source/firFilterTop.sv
//////////////////////////////////////////////////
// Top level of the 20-tap FIR filter.
// Hold loadEnable high until coeffReady rises, then
// drive strobed samples; each result follows 3 edges
// later on filterOut.
//////////////////////////////////////////////////

module firFilterTop (
	input  logic                  clock,
	input  logic                  rst,
	input  logic                  loadEnable,
	input  firPackage::sampleBeat sampleIn,
	output logic                  coeffReady,
	output firPackage::resultBeat filterOut
);

	import firPackage::*;

	// Loader to bank.
	logic                         coeffValid;
	logic signed [coeffWidth-1:0] coeffOut;

	// Input beat after the readiness gate.
	sampleBeat gatedSample;

	// Sample line to product stage.
	logic [tapCount-1:0][sampleWidth-1:0] taps;
	logic                                 lineStrobe;

	// Samples are only accepted while the bank is complete.
	// Anything arriving earlier is dropped here and never reaches the line.
	assign gatedSample.valid = sampleIn.valid & coeffReady;
	assign gatedSample.data  = sampleIn.data;

	firCoeffLoader loader (
		.clock      (clock),
		.rst        (rst),
		.loadEnable (loadEnable),
		.coeffValid (coeffValid),
		.coeffOut   (coeffOut),
		.coeffReady (coeffReady)
	);

	firSampleLine sampleLine (
		.clock      (clock),
		.rst        (rst),
		.sampleIn   (gatedSample),
		.taps       (taps),
		.lineStrobe (lineStrobe)
	);

	firProductSum productSum (
		.clock      (clock),
		.rst        (rst),
		.coeffValid (coeffValid),
		.coeffIn    (coeffOut),
		.taps       (taps),
		.lineStrobe (lineStrobe),
		.filterOut  (filterOut)
	);

	// An accepted sample leaves the filter exactly three edges later.
	assert property (@(posedge clock) disable iff (rst)
		gatedSample.valid |=> ##2 filterOut.valid)
		else $error("accepted sample produced no result after three edges");

endmodule

// File: source/firPackage.sv
//////////////////////////////////////////////////
// Shared definitions for the 20-tap FIR filter.
// Holds the tap count, the datapath widths, the fixed
// coefficient table and the sample and result beats.
// Every RTL file and the testbench import from here.
//////////////////////////////////////////////////

package firPackage;

	// Number of taps in the filter.
	// The coefficient table below fixes this value.
	localparam int tapCount = 20;

	// Input samples are 8-bit two's complement values.
	localparam int sampleWidth = 8;

	// Coefficients are 8-bit two's complement values.
	localparam int coeffWidth = 8;

	// One product of a sample and a coefficient needs the sum of both widths.
	localparam int productWidth = sampleWidth + coeffWidth;

	// Twenty terms need five guard bits above the product width.
	// The sum therefore never overflows.
	localparam int resultWidth = productWidth + 5;

	// Width of the loader's table index.
	// It covers entries 0 to tapCount-1.
	localparam int coeffIndexWidth = 5;

	// The fixed coefficient table, entry 0 first.
	// Entry k multiplies the sample that is k steps old.
	localparam logic signed [coeffWidth-1:0] coeffTable [tapCount] = '{
		8'sd34,  8'sd34,  8'sd0,   8'sd49,  8'sd125,
		-8'sd77, -8'sd51, 8'sd8,   8'sd98,  8'sd109,
		-8'sd91, -8'sd3,  8'sd9,   8'sd1,   8'sd59,
		8'sd75,  8'sd19,  8'sd58,  -8'sd97, 8'sd10
	};

	// One input sample with its strobe.
	// The data field only has meaning while valid is high.
	typedef struct packed {
		logic                          valid;
		logic signed [sampleWidth-1:0] data;
	} sampleBeat;

	// One filter result at full precision with its strobe.
	// No rounding or saturation is applied to the data field.
	typedef struct packed {
		logic                          valid;
		logic signed [resultWidth-1:0] data;
	} resultBeat;

endpackage

// File: source/firProductSum.sv
//////////////////////////////////////////////////
// Coefficient bank and two-stage multiply-add pipeline.
// Coefficients shift into the bank while coeffValid is
// high. Each lineStrobe registers twenty products, and
// the next cycle registers their sum as filterOut.
//////////////////////////////////////////////////

module firProductSum (
	input  logic                                                         clock,
	input  logic                                                         rst,
	input  logic                                                         coeffValid,
	input  logic signed [firPackage::coeffWidth-1:0]                     coeffIn,
	input  logic [firPackage::tapCount-1:0][firPackage::sampleWidth-1:0] taps,
	input  logic                                                         lineStrobe,
	output firPackage::resultBeat                                        filterOut
);

	import firPackage::*;

	// The coefficient bank.
	// New words enter at the top and move down one place per push.
	// After tapCount pushes, position k holds table entry k.
	logic [tapCount-1:0][coeffWidth-1:0] coeffBank;

	// Registered products, one per tap.
	logic signed [productWidth-1:0] products [tapCount];

	// Strobe that travels with the products.
	logic productValid;

	// Combinational sum of all products at full precision.
	logic signed [resultWidth-1:0] productTotal;

	// Bank fill.
	// The bank only moves while the loader pushes words.
	always_ff @(posedge clock) begin
		if (rst) begin
			coeffBank <= '0;
		end else if (coeffValid) begin
			coeffBank <= {coeffIn, coeffBank[tapCount-1:1]};
		end
	end

	// First pipeline stage.
	// Packed array elements are unsigned, so both operands are cast back
	// to signed before the multiply.
	always_ff @(posedge clock) begin
		if (lineStrobe) begin
			for (int k = 0; k < tapCount; k++) begin
				products[k] <= $signed(taps[k]) * $signed(coeffBank[k]);
			end
		end
	end

	// The strobe of the first stage.
	always_ff @(posedge clock) begin
		if (rst) begin
			productValid <= 1'b0;
		end else begin
			productValid <= lineStrobe;
		end
	end

	// Adder tree over the products.
	// Each term is sign extended to the result width before it is added.
	always_comb begin
		productTotal = '0;
		for (int k = 0; k < tapCount; k++) begin
			productTotal = productTotal + products[k];
		end
	end

	// Second pipeline stage.
	// The data field is payload and only the strobe is reset.
	always_ff @(posedge clock) begin
		if (rst) begin
			filterOut.valid <= 1'b0;
		end else begin
			filterOut.valid <= productValid;
		end
	end

	always_ff @(posedge clock) begin
		if (productValid) begin
			filterOut.data <= productTotal;
		end
	end

	// Every new set of taps yields exactly one result two cycles later.
	assert property (@(posedge clock) disable iff (rst)
		filterOut.valid == $past(lineStrobe, 2))
		else $error("filter output strobe out of step with the sample line");

endmodule

// File: source/firSampleLine.sv
//////////////////////////////////////////////////
// Delay line of accepted input samples.
// Each valid beat shifts a new sample into tap 0 and
// raises lineStrobe for one cycle.
//////////////////////////////////////////////////

module firSampleLine (
	input  logic                                                         clock,
	input  logic                                                         rst,
	input  firPackage::sampleBeat                                        sampleIn,
	output logic [firPackage::tapCount-1:0][firPackage::sampleWidth-1:0] taps,
	output logic                                                         lineStrobe
);

	import firPackage::*;

	// The shift register.
	// Tap 0 holds the newest sample and tap tapCount-1 the oldest one.
	// The line only moves on a valid beat, so gaps in the input stream
	// do not age the history.
	always_ff @(posedge clock) begin
		if (rst) begin
			taps <= '0;
		end else if (sampleIn.valid) begin
			taps <= {taps[tapCount-2:0], sampleIn.data};
		end
	end

	// Tells the product stage that the taps changed on this edge.
	// It is high for one cycle per accepted sample.
	always_ff @(posedge clock) begin
		if (rst) begin
			lineStrobe <= 1'b0;
		end else begin
			lineStrobe <= sampleIn.valid;
		end
	end

	// Every accepted sample must show up in tap 0 on the next cycle,
	// with the strobe marking exactly that cycle.
	assert property (@(posedge clock) disable iff (rst)
		sampleIn.valid |=> (lineStrobe && taps[0] == $past(sampleIn.data)))
		else $error("accepted sample missing from tap 0");

endmodule

// File: test/firFilterBench.sv
//////////////////////////////////////////////////
// Testbench for the 20-tap FIR filter top level.
// Applies a table of steps one clock at a time, models
// the convolution and checks every result beat.
//////////////////////////////////////////////////

module firFilterBench;

	import firPackage::*;

	// One row of the stimulus table.
	// A row is applied repeatCount times in a row.
	typedef struct packed {
		logic       loadLevel;
		logic       sampleValid;
		logic       randomData;
		logic [7:0] sampleData;
		logic [7:0] repeatCount;
		logic       readyExpected;
	} stepEntry;

	// One result that the model expects, with the cycle it must appear in.
	typedef struct packed {
		logic signed [31:0] value;
		logic [31:0]        arrival;
	} expectedBeat;

	// Idle cycles allowed for the last results to drain.
	localparam int drainLimit = 10;

	logic      clock;
	logic      rst;
	logic      loadEnable;
	sampleBeat sampleIn;
	logic      coeffReady;
	resultBeat filterOut;

	stepEntry    stepTable [$];
	string       stepNames [$];
	expectedBeat expectQueue [$];
	string       nameQueue [$];

	// Model history of accepted samples, newest at index 0.
	int history [tapCount];
	int cycleCount;
	int seed = 58703;

	firFilterTop UUT (
		.clock      (clock),
		.rst        (rst),
		.loadEnable (loadEnable),
		.sampleIn   (sampleIn),
		.coeffReady (coeffReady),
		.filterOut  (filterOut)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic stopWithFailure();
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic compareValue(string testName, int expected, int actual);
		if (expected !== actual) begin
			$display("error %s: expected %0d, actual %0d", testName, expected, actual);
			stopWithFailure();
		end
	endtask

	task automatic addStep(string name, logic load, logic valid, logic randomFlag,
			logic [7:0] data, int count, logic ready);
		stepEntry entry;
		entry.loadLevel     = load;
		entry.sampleValid   = valid;
		entry.randomData    = randomFlag;
		entry.sampleData    = data;
		entry.repeatCount   = 8'(count);
		entry.readyExpected = ready;
		stepTable.push_back(entry);
		stepNames.push_back(name);
	endtask

	// The ready column follows the loader timing.
	// Ready is seen one full table length after the first high enable,
	// and it is gone one edge after the enable drops.
	task automatic buildTable();
		//       name                    load valid rand data   count ready
		addStep("idle after reset",       0,   0,    0,   8'h00, 3,    0);
		addStep("samples while unloaded", 0,   1,    1,   8'h00, 6,    0);
		addStep("load in progress",       1,   0,    0,   8'h00, 20,   0);
		addStep("load complete",          1,   0,    0,   8'h00, 2,    1);
		addStep("impulse",                1,   1,    0,   8'h01, 1,    1);
		addStep("impulse tail",           1,   1,    0,   8'h00, 19,   1);
		addStep("random back to back",    1,   1,    1,   8'h00, 30,   1);
		addStep("minimum samples",        1,   1,    0,   8'h80, 20,   1);
		addStep("maximum samples",        1,   1,    0,   8'h7f, 4,    1);
		addStep("gap",                    1,   0,    0,   8'h00, 2,    1);
		addStep("random gapped",          1,   1,    1,   8'h00, 1,    1);
		addStep("gap",                    1,   0,    0,   8'h00, 1,    1);
		addStep("random gapped",          1,   1,    1,   8'h00, 2,    1);
		addStep("gap",                    1,   0,    0,   8'h00, 3,    1);
		addStep("random gapped",          1,   1,    1,   8'h00, 1,    1);
		addStep("enable drop",            0,   0,    0,   8'h00, 1,    1);
		addStep("samples while dropped",  0,   1,    1,   8'h00, 4,    0);
		addStep("reload in progress",     1,   1,    1,   8'h00, 20,   0);
		addStep("after reload",           1,   1,    1,   8'h00, 25,   1);
	endtask

	// Reference model of one accepted sample.
	// The result is the plain convolution of the history with the table.
	task automatic acceptSample(string testName, logic signed [7:0] data);
		expectedBeat beat;
		int total;
		for (int k = tapCount - 1; k > 0; k--) begin
			history[k] = history[k - 1];
		end
		history[0] = data;
		total = 0;
		for (int k = 0; k < tapCount; k++) begin
			total = total + int'(coeffTable[k]) * history[k];
		end
		beat.value   = total;
		// Sampled on the next edge, result two edges after that.
		beat.arrival = cycleCount + 3;
		expectQueue.push_back(beat);
		nameQueue.push_back(testName);
	endtask

	// Called in the middle of every cycle, when filterOut is stable.
	task automatic checkOutput();
		expectedBeat front;
		string frontName;
		int actual;
		if (filterOut.valid) begin
			if (expectQueue.size() == 0) begin
				$display("a result came out at cycle %0d with no sample waiting for it",
					cycleCount);
				stopWithFailure();
			end
			front     = expectQueue.pop_front();
			frontName = nameQueue.pop_front();
			actual    = int'($signed(filterOut.data));
			compareValue({frontName, " result"}, front.value, actual);
			compareValue({frontName, " latency"}, int'(front.arrival), cycleCount);
		end else if (expectQueue.size() != 0 && expectQueue[0].arrival <= cycleCount) begin
			$display("the result for %s did not come out at cycle %0d",
				nameQueue[0], expectQueue[0].arrival);
			stopWithFailure();
		end
	endtask

	// One cycle with no new sample, still watching the output.
	task automatic idleCycle();
		@(posedge clock);
		cycleCount++;
		sampleIn.valid <= 1'b0;
		@(negedge clock);
		checkOutput();
	endtask

	initial begin
		stepEntry entry;
		logic [7:0] data;
		int waited;
		loadEnable = 1'b0;
		sampleIn   = '0;
		rst        = 1'b1;
		cycleCount = 0;
		for (int k = 0; k < tapCount; k++) begin
			history[k] = 0;
		end
		buildTable();

		repeat (10) @(posedge clock);
		rst <= 1'b0;

		// Each repetition of a row is one clock.
		// Inputs change just after the edge and everything is checked mid cycle.
		for (int i = 0; i < stepTable.size(); i++) begin
			entry = stepTable[i];
			for (int r = 0; r < entry.repeatCount; r++) begin
				@(posedge clock);
				cycleCount++;
				data = entry.randomData ? 8'($random(seed)) : entry.sampleData;
				loadEnable     <= entry.loadLevel;
				sampleIn.valid <= entry.sampleValid;
				sampleIn.data  <= data;
				@(negedge clock);
				checkOutput();
				compareValue({stepNames[i], " coeffReady"},
					int'(entry.readyExpected), int'(coeffReady));
				// The gate uses the ready level seen before the next edge.
				if (entry.sampleValid && entry.readyExpected) begin
					acceptSample(stepNames[i], data);
				end
			end
		end

		// Let the samples still in the pipeline come out.
		waited = 0;
		while (expectQueue.size() != 0) begin
			if (waited == drainLimit) begin
				$display("results were still missing after %0d idle cycles", drainLimit);
				stopWithFailure();
			end
			idleCycle();
			waited++;
		end

		// No stray beats may follow the last one.
		repeat (5) idleCycle();

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule
